// ==== logic/isaPkg.sv ====
package isaPkg;

  // Datapath and instruction field widths
  localparam int dataW = 16;
  localparam int regAddrW = 4;
  localparam int opcodeW = 4;
  localparam int immW = 12;
  localparam int shamtW = 4;
  // Branch offset, memory offset and byte immediate widths
  localparam int brOffW = 9;
  localparam int memOffW = 4;
  localparam int byteW = 8;

  // jal writes its return address here
  localparam logic [regAddrW-1:0] linkReg = 4'd15;

  // Top four bits of the instruction word
  typedef enum logic [opcodeW-1:0] {
    opAdd  = 4'b0000,
    opAddz = 4'b0001,
    opSub  = 4'b0010,
    opAnd  = 4'b0011,
    opNor  = 4'b0100,
    opSll  = 4'b0101,
    opSrl  = 4'b0110,
    opSra  = 4'b0111,
    opLw   = 4'b1000,
    opSw   = 4'b1001,
    opLhb  = 4'b1010,
    opLlb  = 4'b1011,
    opB    = 4'b1100,
    opJal  = 4'b1101,
    opJr   = 4'b1110,
    opHlt  = 4'b1111
  } opcodeT;

  // Low opcodes map straight onto these
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluLhb = 3'b001,
    aluSub = 3'b010,
    aluAnd = 3'b011,
    aluNor = 3'b100,
    aluSll = 3'b101,
    aluSrl = 3'b110,
    aluSra = 3'b111
  } aluOpT;

  // Branch condition field, bits 11..9
  typedef enum logic [2:0] {
    bcNeq    = 3'b000,
    bcEq     = 3'b001,
    bcGt     = 3'b010,
    bcLt     = 3'b011,
    bcGte    = 3'b100,
    bcLte    = 3'b101,
    bcOvf    = 3'b110,
    bcAlways = 3'b111
  } branchCondT;

  typedef struct packed {
    logic [regAddrW-1:0] p0Addr;
    logic [regAddrW-1:0] p1Addr;
    logic [regAddrW-1:0] regAddr;
    logic [immW-1:0] imm;
    logic [shamtW-1:0] shamt;
    aluOpT aluOp;
    branchCondT branchOp;
    logic regWe;
    logic memRe;
    logic memWe;
    logic memToReg;
    logic addz;
    logic branch;
    logic jal;
    logic jr;
    logic halt;
    // Src0 picks the byte immediate, src1 the memory offset
    logic aluSrc0;
    logic aluSrc1;
    // Flag update enables
    logic ovEn;
    logic zrEn;
    logic neEn;
  } decodeT;

endpackage

// ==== logic/busPkg.sv ====
package busPkg;

  // Word addressed, one word per transfer
  localparam int wbAdrW = 16;
  localparam int wbDatW = 16;

  // Master to slave
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [wbAdrW-1:0] adr;
    logic [wbDatW-1:0] dat;
  } wbReqT;

  // Slave to master
  typedef struct packed {
    logic [wbDatW-1:0] dat;
    logic ack;
  } wbRspT;

endpackage

// ==== logic/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder import isaPkg::*; (
  input  logic [dataW-1:0] instr,
  output decodeT dec
);

  opcodeT opc;
  logic isAlu;
  logic isLw;
  logic isSw;
  logic isLhb;
  logic isLlb;

  assign opc = opcodeT'(instr[dataW-1 -: opcodeW]);

  // Top bit clear means a register ALU op
  assign isAlu = !instr[dataW-1];
  assign isLw = (opc == opLw);
  assign isSw = (opc == opSw);
  assign isLhb = (opc == opLhb);
  assign isLlb = (opc == opLlb);

  always_comb begin
    dec = '0;
    dec.imm = instr[immW-1:0];
    dec.shamt = instr[shamtW-1:0];
    dec.branchOp = branchCondT'(instr[11:9]);

    // lhb reads its own destination so the low byte survives
    dec.p0Addr = isLhb ? instr[11:8] : instr[7:4];
    // Store data and lhb come from 11..8 and the lw base from 7..4
    if (isSw || isLhb) begin
      dec.p1Addr = instr[11:8];
    end else if (isLw) begin
      dec.p1Addr = instr[7:4];
    end else if (isLlb) begin
      dec.p1Addr = '0;
    end else begin
      dec.p1Addr = instr[3:0];
    end

    // Return address goes to the link register
    dec.regAddr = (opc == opJal) ? linkReg : instr[11:8];

    dec.addz = (opc == opAddz);
    dec.branch = (opc == opB);
    dec.jal = (opc == opJal);
    dec.jr = (opc == opJr);
    dec.halt = (opc == opHlt);
    dec.memRe = isLw;
    dec.memWe = isSw;
    dec.memToReg = isLw;

    // addz write is decided in the core against the zero flag
    dec.regWe = !dec.addz && !isSw && !dec.branch && !dec.jr && !dec.halt;

    // Flags only follow arithmetic and logic ops
    dec.ovEn = (opc == opAdd) || dec.addz || (opc == opSub);
    dec.neEn = dec.ovEn;
    dec.zrEn = isAlu;

    dec.aluSrc0 = isLlb || isLhb;
    dec.aluSrc1 = isLw || isSw;

    // Low opcodes pass their operation through and addz is a plain add
    if (isAlu) begin
      dec.aluOp = dec.addz ? aluAdd : aluOpT'(instr[14:12]);
    end else if (isLhb) begin
      dec.aluOp = aluLhb;
    end else begin
      // lw, sw and llb all add; branches write nothing
      dec.aluOp = aluAdd;
    end
  end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/100ps

module regFile import isaPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic [regAddrW-1:0] rdAddr0,
  input  logic [regAddrW-1:0] rdAddr1,
  output logic [dataW-1:0] rdData0,
  output logic [dataW-1:0] rdData1,
  input  logic we,
  input  logic [regAddrW-1:0] wrAddr,
  input  logic [dataW-1:0] wrData
);

  localparam int numRegs = 1 << regAddrW;

  // R0 has no storage
  logic [dataW-1:0] regs [1:numRegs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads are combinational
  assign rdData0 = (rdAddr0 == '0) ? '0 : regs[rdAddr0];
  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu import isaPkg::*; (
  input  logic [dataW-1:0] src0,
  input  logic [dataW-1:0] src1,
  input  logic [shamtW-1:0] shamt,
  input  aluOpT op,
  output logic [dataW-1:0] result,
  output logic ovf,
  output logic zero,
  output logic neg
);

  // Signed limits for saturation
  localparam logic [dataW-1:0] maxPos = {1'b0, {(dataW-1){1'b1}}};
  localparam logic [dataW-1:0] maxNeg = {1'b1, {(dataW-1){1'b0}}};

  logic [dataW-1:0] sum;
  logic [dataW-1:0] diff;
  logic sumOvf;
  logic diffOvf;

  assign sum = src0 + src1;
  assign diff = src0 - src1;

  // Same-sign operands with a flipped result sign
  assign sumOvf = (src0[dataW-1] == src1[dataW-1]) && (sum[dataW-1] != src0[dataW-1]);
  // Opposite-sign operands and the result takes the subtrahend sign
  assign diffOvf = (src0[dataW-1] != src1[dataW-1]) && (diff[dataW-1] != src0[dataW-1]);

  always_comb begin
    ovf = 1'b0;
    unique case (op)
      aluAdd: begin
        ovf = sumOvf;
        // Clamp toward the sign of the operands
        if (sumOvf) begin
          result = src0[dataW-1] ? maxNeg : maxPos;
        end else begin
          result = sum;
        end
      end
      aluSub: begin
        ovf = diffOvf;
        if (diffOvf) begin
          result = src0[dataW-1] ? maxNeg : maxPos;
        end else begin
          result = diff;
        end
      end
      // Keep low byte, take new high byte from the immediate
      aluLhb: result = {src1[byteW-1:0], src0[byteW-1:0]};
      aluAnd: result = src0 & src1;
      aluNor: result = ~(src0 | src1);
      aluSll: result = src0 << shamt;
      aluSrl: result = src0 >> shamt;
      aluSra: result = $signed(src0) >>> shamt;
      default: result = '0;
    endcase
  end

  // Flag candidates; branchUnit decides whether they stick
  assign zero = (result == '0);
  assign neg = result[dataW-1];

endmodule

// ==== logic/branchUnit.sv ====
`timescale 1ns/100ps

module branchUnit import isaPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic retire,
  input  logic [dataW-1:0] pc,
  input  decodeT dec,
  input  logic [dataW-1:0] jrTarget,
  input  logic ovf,
  input  logic zero,
  input  logic neg,
  output logic [dataW-1:0] nextPc,
  output logic zeroFlag
);

  logic ovfQ;
  logic zeroQ;
  logic negQ;
  logic taken;
  logic [dataW-1:0] pcPlus1;
  logic [dataW-1:0] brOff;
  logic [dataW-1:0] jalOff;

  // Each flag only moves when its instruction enables it
  always_ff @(posedge clk) begin
    if (rst) begin
      ovfQ <= 1'b0;
      zeroQ <= 1'b0;
      negQ <= 1'b0;
    end else if (retire) begin
      if (dec.ovEn) ovfQ <= ovf;
      if (dec.zrEn) zeroQ <= zero;
      if (dec.neEn) negQ <= neg;
    end
  end

  // Conditions test the stored flags, not this instruction's
  always_comb begin
    unique case (dec.branchOp)
      bcNeq:    taken = !zeroQ;
      bcEq:     taken = zeroQ;
      bcGt:     taken = !zeroQ && !negQ;
      bcLt:     taken = negQ;
      bcGte:    taken = zeroQ || !negQ;
      bcLte:    taken = zeroQ || negQ;
      bcOvf:    taken = ovfQ;
      bcAlways: taken = 1'b1;
      default:  taken = 1'b0;
    endcase
  end

  assign pcPlus1 = pc + 1'b1;
  assign brOff = {{(dataW-brOffW){dec.imm[brOffW-1]}}, dec.imm[brOffW-1:0]};
  assign jalOff = {{(dataW-immW){dec.imm[immW-1]}}, dec.imm};

  always_comb begin
    if (dec.jr) begin
      nextPc = jrTarget;
    end else if (dec.jal) begin
      nextPc = pcPlus1 + jalOff;
    end else if (dec.branch && taken) begin
      nextPc = pcPlus1 + brOff;
    end else if (dec.halt) begin
      // PC parks on the halt instruction
      nextPc = pc;
    end else begin
      nextPc = pcPlus1;
    end
  end

  assign zeroFlag = zeroQ;

endmodule

// ==== logic/dataBusMaster.sv ====
`timescale 1ns/100ps

module dataBusMaster import busPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic write,
  input  logic [wbAdrW-1:0] adr,
  input  logic [wbDatW-1:0] wdat,
  output wbReqT wb,
  input  wbRspT wbIn,
  output logic done,
  output logic [wbDatW-1:0] rdat
);

  logic busy;
  logic weQ;
  logic [wbAdrW-1:0] adrQ;
  logic [wbDatW-1:0] datQ;

  // Cycle opens on start and closes the edge after ack
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (busy && wbIn.ack) begin
      busy <= 1'b0;
    end
  end

  // Request held constant for the whole transfer
  always_ff @(posedge clk) begin
    if (start) begin
      weQ <= write;
      adrQ <= adr;
      datQ <= wdat;
    end
  end

  assign wb = '{cyc: busy, stb: busy, we: weQ, adr: adrQ, dat: datQ};

  // Ack outside our strobe is ignored
  assign done = wbIn.ack && wb.stb;
  assign rdat = wbIn.dat;

  // Stalled transfer keeps its address and direction
  reqStable: assert property (@(posedge clk) disable iff (rst)
    (wb.stb && !wbIn.ack) |=> wb.stb && $stable(wb.adr) && $stable(wb.we));
  noStartBusy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore import isaPkg::*, busPkg::*; (
  input  logic clk,
  input  logic rst,
  output logic [dataW-1:0] instrAddr,
  input  logic [dataW-1:0] instr,
  output wbReqT wb,
  input  wbRspT wbIn,
  output logic halted
);

  typedef enum logic [1:0] {
    stRun,
    stMemWait,
    stHalt
  } stateT;

  stateT state;
  decodeT dec;
  logic [dataW-1:0] pc;
  logic [dataW-1:0] nextPc;
  logic [dataW-1:0] rdData0;
  logic [dataW-1:0] rdData1;
  logic [dataW-1:0] aluSrc0;
  logic [dataW-1:0] aluSrc1;
  logic [dataW-1:0] aluResult;
  logic aluOvf;
  logic aluZero;
  logic aluNeg;
  logic zeroFlag;
  logic isMem;
  logic memStart;
  logic memDone;
  logic [wbDatW-1:0] memRdat;
  logic retire;
  logic regWe;
  logic [dataW-1:0] wrData;

  instrDecoder decoder (.instr(instr), .dec(dec));

  regFile regs (
    .clk(clk), .rst(rst),
    .rdAddr0(dec.p0Addr), .rdAddr1(dec.p1Addr),
    .rdData0(rdData0), .rdData1(rdData1),
    .we(regWe), .wrAddr(dec.regAddr), .wrData(wrData)
  );

  // llb adds its byte to zero; lhb still needs its own register on port 0
  assign aluSrc0 = (dec.aluSrc0 && dec.aluOp == aluAdd) ? '0 : rdData0;

  always_comb begin
    if (dec.aluSrc1) begin
      // Memory offset, 4 bits signed
      aluSrc1 = {{(dataW-memOffW){dec.imm[memOffW-1]}}, dec.imm[memOffW-1:0]};
    end else if (dec.aluSrc0) begin
      aluSrc1 = {{(dataW-byteW){dec.imm[byteW-1]}}, dec.imm[byteW-1:0]};
    end else begin
      aluSrc1 = rdData1;
    end
  end

  alu aluUnit (
    .src0(aluSrc0), .src1(aluSrc1), .shamt(dec.shamt), .op(dec.aluOp),
    .result(aluResult), .ovf(aluOvf), .zero(aluZero), .neg(aluNeg)
  );

  // jr target read through port 0
  branchUnit brUnit (
    .clk(clk), .rst(rst), .retire(retire), .pc(pc), .dec(dec),
    .jrTarget(rdData0), .ovf(aluOvf), .zero(aluZero), .neg(aluNeg),
    .nextPc(nextPc), .zeroFlag(zeroFlag)
  );

  assign isMem = dec.memRe || dec.memWe;
  // Bus cycle is requested from the first cycle of a load or store
  assign memStart = (state == stRun) && isMem;

  dataBusMaster busMaster (
    .clk(clk), .rst(rst), .start(memStart), .write(dec.memWe),
    .adr(aluResult), .wdat(rdData1), .wb(wb), .wbIn(wbIn),
    .done(memDone), .rdat(memRdat)
  );

  // One instruction in flight; memory ops retire on ack
  assign retire = ((state == stRun) && !isMem) || ((state == stMemWait) && memDone);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stRun;
      pc <= '0;
    end else begin
      if (retire) pc <= nextPc;
      unique case (state)
        stRun: begin
          if (dec.halt) state <= stHalt;
          else if (isMem) state <= stMemWait;
        end
        stMemWait: if (memDone) state <= stRun;
        stHalt: state <= stHalt;
        default: state <= stRun;
      endcase
    end
  end

  // addz writes only on a stored zero flag
  assign regWe = retire && (dec.regWe || (dec.addz && zeroFlag));

  always_comb begin
    if (dec.memToReg) wrData = memRdat;
    else if (dec.jal) wrData = pc + 1'b1;
    else wrData = aluResult;
  end

  assign instrAddr = pc;
  assign halted = (state == stHalt);

  // Instruction stays presented while the bus stalls
  pcHeldInWait: assert property (@(posedge clk) disable iff (rst)
    (state == stMemWait && !memDone) |=> pc == $past(pc));

endmodule

// ==== sim/wbMemModel.sv ====
`timescale 1ns/100ps

module wbMemModel import busPkg::*; (
  input  logic clk,
  input  logic rst,
  input  wbReqT wb,
  output wbRspT wbOut,
  input  logic [1:0] ackDelay,
  output logic storeStb,
  output logic [wbAdrW-1:0] storeAdr,
  output logic [wbDatW-1:0] storeDat
);

  localparam int depth = 256;
  localparam int idxW = $clog2(depth);

  logic [wbDatW-1:0] mem [0:depth-1];
  logic active;
  logic [1:0] waitCnt;

  // Every word starts with its own value
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = 16'(i) * 16'h9E37 + 16'h1234;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      waitCnt <= '0;
      wbOut <= '0;
    end else begin
      // Ack is a single-cycle pulse
      wbOut.ack <= 1'b0;
      if (wb.cyc && wb.stb && !wbOut.ack) begin
        if (!active) begin
          // Fresh delay latched as the transfer opens
          active <= 1'b1;
          waitCnt <= ackDelay;
        end else if (waitCnt != '0) begin
          waitCnt <= waitCnt - 1'b1;
        end else begin
          active <= 1'b0;
          wbOut.ack <= 1'b1;
          if (wb.we) begin
            mem[wb.adr[idxW-1:0]] <= wb.dat;
          end else begin
            wbOut.dat <= mem[wb.adr[idxW-1:0]];
          end
        end
      end
    end
  end

  // Store log, valid in the ack cycle of a write
  assign storeStb = wbOut.ack && wb.stb && wb.we;
  assign storeAdr = wb.adr;
  assign storeDat = wb.dat;

endmodule

// ==== sim/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb import isaPkg::*, busPkg::*; ();

  localparam int clkPeriod = 10;
  localparam int progSize = 128;
  localparam int maxSteps = 1000;
  // Worst case cycles for one load or store
  localparam int maxLatency = 6;
  localparam logic [dataW-1:0] haltWord = {opHlt, 12'h000};

  logic clk;
  logic rst;
  logic [1:0] ackDelay;
  logic [dataW-1:0] instrAddr;
  logic [dataW-1:0] instr;
  logic halted;
  wbReqT wbReq;
  wbRspT wbRsp;
  logic storeStb;
  logic [wbAdrW-1:0] storeAdr;
  logic [wbDatW-1:0] storeDat;

  logic [dataW-1:0] prog [0:progSize-1];
  int progLen;
  logic [31:0] lcgState;
  logic [wbAdrW-1:0] expAdr [$];
  logic [wbDatW-1:0] expDat [$];
  int refSteps;
  int storeIdx;
  int valueErrors;
  int otherErrors;
  logic refReady;
  time timeLimit;
  logic [dataW-1:0] finalPc;

  cpuCore uut (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .wb(wbReq), .wbIn(wbRsp), .halted(halted)
  );

  wbMemModel memModel (
    .clk(clk), .rst(rst), .wb(wbReq), .wbOut(wbRsp), .ackDelay(ackDelay),
    .storeStb(storeStb), .storeAdr(storeAdr), .storeDat(storeDat)
  );

  // Past the end of the program the core sees halt
  assign instr = (instrAddr < progLen) ? prog[instrAddr] : haltWord;

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [15:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[30:15];
  endfunction

  function automatic logic [dataW-1:0] aluInstr(opcodeT op, logic [3:0] rd, logic [3:0] rs,
                                                logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  // Register, base register, signed 4-bit offset
  function automatic logic [dataW-1:0] memInstr(opcodeT op, logic [3:0] r, logic [3:0] base,
                                                logic [3:0] off);
    return {op, r, base, off};
  endfunction

  function automatic logic [dataW-1:0] byteInstr(opcodeT op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic appendInstr(input logic [dataW-1:0] w);
    prog[progLen] = w;
    progLen++;
  endtask

  task automatic buildProgram();
    int setup;
    progLen = 0;
    // Two random constants from byte halves and bases at 0x40 and 0x60
    appendInstr(byteInstr(opLlb, 4'd1, 8'(nextRand())));
    appendInstr(byteInstr(opLhb, 4'd1, 8'(nextRand())));
    appendInstr(byteInstr(opLlb, 4'd2, 8'(nextRand())));
    appendInstr(byteInstr(opLhb, 4'd2, 8'(nextRand())));
    appendInstr(byteInstr(opLlb, 4'd13, 8'h40));
    appendInstr(byteInstr(opLlb, 4'd14, 8'h60));
    appendInstr(memInstr(opSw, 4'd1, 4'd13, 4'd0));
    appendInstr(memInstr(opSw, 4'd2, 4'd13, 4'd1));
    // One result per ALU operation
    appendInstr(aluInstr(opAdd, 4'd3, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd3, 4'd13, 4'd2));
    appendInstr(aluInstr(opSub, 4'd4, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd4, 4'd13, 4'd3));
    appendInstr(aluInstr(opAnd, 4'd5, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd5, 4'd13, 4'd4));
    appendInstr(aluInstr(opNor, 4'd6, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd6, 4'd13, 4'd5));
    appendInstr(aluInstr(opSll, 4'd7, 4'd1, 4'(nextRand())));
    appendInstr(memInstr(opSw, 4'd7, 4'd13, 4'd6));
    appendInstr(aluInstr(opSrl, 4'd8, 4'd2, 4'(nextRand())));
    appendInstr(memInstr(opSw, 4'd8, 4'd13, 4'd7));
    appendInstr(aluInstr(opSra, 4'd9, 4'd1, 4'(nextRand())));
    appendInstr(memInstr(opSw, 4'd9, 4'd13, 4'hF));
    // 0x7F7F and 0x8080 push add and sub into saturation
    appendInstr(byteInstr(opLlb, 4'd10, 8'h7F));
    appendInstr(byteInstr(opLhb, 4'd10, 8'h7F));
    appendInstr(byteInstr(opLlb, 4'd12, 8'h80));
    appendInstr(byteInstr(opLhb, 4'd12, 8'h80));
    appendInstr(aluInstr(opAdd, 4'd11, 4'd10, 4'd10));
    appendInstr(memInstr(opSw, 4'd11, 4'd13, 4'hE));
    appendInstr(aluInstr(opSub, 4'd11, 4'd12, 4'd10));
    appendInstr(memInstr(opSw, 4'd11, 4'd13, 4'hD));
    // Read back stored words and one untouched word
    appendInstr(memInstr(opLw, 4'd3, 4'd13, 4'd2));
    appendInstr(memInstr(opSw, 4'd3, 4'd14, 4'd0));
    appendInstr(memInstr(opLw, 4'd4, 4'd13, 4'hF));
    appendInstr(memInstr(opSw, 4'd4, 4'd14, 4'd1));
    appendInstr(memInstr(opLw, 4'd5, 4'd13, 4'h8));
    appendInstr(memInstr(opSw, 4'd5, 4'd14, 4'd2));
    // addz after a zero result, then after a nonzero one
    appendInstr(aluInstr(opSub, 4'd6, 4'd1, 4'd1));
    appendInstr(aluInstr(opAddz, 4'd7, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd7, 4'd14, 4'd3));
    appendInstr(aluInstr(opAdd, 4'd6, 4'd10, 4'd0));
    appendInstr(aluInstr(opAddz, 4'd8, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd8, 4'd14, 4'd4));
    // Every condition against zero, overflow-negative and positive flags
    for (int pass = 0; pass < 3; pass++) begin
      for (int c = 0; c < 8; c++) begin
        setup = (c + pass) % 3;
        if (setup == 0) begin
          appendInstr(aluInstr(opSub, 4'd6, 4'd1, 4'd1));
        end else if (setup == 1) begin
          appendInstr(aluInstr(opSub, 4'd6, 4'd12, 4'd10));
        end else begin
          appendInstr(aluInstr(opAdd, 4'd6, 4'd10, 4'd0));
        end
        // Taken branch skips the store
        appendInstr({opB, 3'(c), 9'd1});
        appendInstr(memInstr(opSw, 4'(pass + 1), 4'd14, 4'(c - 8)));
      end
    end
    // Call over the halt into the routine
    appendInstr({opJal, 12'd2});
    appendInstr(memInstr(opSw, linkReg, 4'd14, 4'd5));
    appendInstr(haltWord);
    appendInstr(aluInstr(opAdd, 4'd9, 4'd1, 4'd2));
    appendInstr(memInstr(opSw, 4'd9, 4'd14, 4'd6));
    appendInstr({opJr, 4'd0, linkReg, 4'd0});
  endtask

  function automatic logic [dataW-1:0] fetchWord(input logic [dataW-1:0] a);
    return (a < progLen) ? prog[a] : haltWord;
  endfunction

  // Clamp to the signed 16-bit range
  function automatic logic [dataW-1:0] saturate(input int s, output logic ov);
    ov = (s > 32767) || (s < -32768);
    if (s > 32767) return 16'h7FFF;
    if (s < -32768) return 16'h8000;
    return 16'(s);
  endfunction

  function automatic logic condTaken(branchCondT c, logic z, logic n, logic v);
    case (c)
      bcNeq: return !z;
      bcEq: return z;
      bcGt: return !z && !n;
      bcLt: return n;
      bcGte: return z || !n;
      bcLte: return z || n;
      bcOvf: return v;
      default: return 1'b1;
    endcase
  endfunction

  // ISA model that fills the expected store queues and returns the halt PC
  function automatic logic [dataW-1:0] runReference();
    logic [dataW-1:0] r [0:15];
    logic [dataW-1:0] dmem [0:255];
    logic [dataW-1:0] pc;
    logic [dataW-1:0] npc;
    logic [dataW-1:0] w;
    logic [dataW-1:0] res;
    logic [dataW-1:0] adr;
    opcodeT op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    logic zf;
    logic nf;
    logic vf;
    logic ov;
    logic wr;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 16'(i) * 16'h9E37 + 16'h1234;
    end
    pc = '0;
    zf = 1'b0;
    nf = 1'b0;
    vf = 1'b0;
    adr = '0;
    refSteps = 0;
    while (refSteps < maxSteps) begin
      w = fetchWord(pc);
      op = opcodeT'(w[15:12]);
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      refSteps++;
      if (op == opHlt) break;
      ov = 1'b0;
      res = '0;
      npc = pc + 1'b1;
      case (op)
        opAdd, opAddz: res = saturate(int'($signed(r[rs])) + int'($signed(r[rt])), ov);
        opSub: res = saturate(int'($signed(r[rs])) - int'($signed(r[rt])), ov);
        opAnd: res = r[rs] & r[rt];
        opNor: res = ~(r[rs] | r[rt]);
        opSll: res = r[rs] << rt;
        opSrl: res = r[rs] >> rt;
        opSra: res = $signed(r[rs]) >>> rt;
        opLw, opSw: adr = saturate(int'($signed(r[rs])) + int'($signed(rt)), ov);
        opLhb: res = {w[7:0], r[rd][7:0]};
        opLlb: res = {{8{w[7]}}, w[7:0]};
        opB: begin
          if (condTaken(branchCondT'(w[11:9]), zf, nf, vf)) begin
            npc = pc + 1'b1 + {{7{w[8]}}, w[8:0]};
          end
        end
        opJal: npc = pc + 1'b1 + {{4{w[11]}}, w[11:0]};
        opJr: npc = r[rs];
        default: ;
      endcase
      if (op == opLw) res = dmem[adr[7:0]];
      if (op == opSw) begin
        dmem[adr[7:0]] = r[rd];
        expAdr.push_back(adr);
        expDat.push_back(r[rd]);
      end
      // addz looks at the flag left by the instruction before it
      if (op == opAddz) wr = zf;
      else wr = (op <= opLw) || (op == opLhb) || (op == opLlb);
      if (op == opJal) r[linkReg] = pc + 1'b1;
      else if (wr && rd != 4'd0) r[rd] = res;
      if (op < opLw) begin
        zf = (res == '0);
        if (op == opAdd || op == opAddz || op == opSub) begin
          vf = ov;
          nf = res[15];
        end
      end
      pc = npc;
    end
    return pc;
  endfunction

  task automatic finishRun();
    $display("Summary: %0d of %0d stores seen, %0d value mismatches, %0d other errors",
             storeIdx, expAdr.size(), valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // New ack delay each cycle; the memory takes it when a transfer opens
  always @(posedge clk) begin
    ackDelay <= 2'(nextRand());
  end

  // Each completed write against the next expected store
  always @(posedge clk) begin
    if (!rst) begin
      if (storeStb) begin
        if (storeIdx >= expAdr.size()) begin
          otherErrors++;
          $display("Unexpected extra store of %h to %h at %0t", storeDat, storeAdr, $time);
        end else if (storeAdr != expAdr[storeIdx] || storeDat != expDat[storeIdx]) begin
          valueErrors++;
          $display("FAILED at %0t: store %0d expected %h <= %h, got %h <= %h", $time,
                   storeIdx, expAdr[storeIdx], expDat[storeIdx], storeAdr, storeDat);
        end
        storeIdx++;
      end
      if (halted && wbReq.cyc) begin
        otherErrors++;
        $display("Bus cycle open after halt at %0t", $time);
      end
    end
  end

  initial begin
    rst = 1'b1;
    ackDelay = 2'd0;
    lcgState = 32'd20;
    storeIdx = 0;
    valueErrors = 0;
    otherErrors = 0;
    refReady = 1'b0;
    buildProgram();
    finalPc = runReference();
    if (fetchWord(finalPc) != haltWord) begin
      otherErrors++;
      $display("Reference model never reached a halt within %0d steps", maxSteps);
    end
    timeLimit = clkPeriod * (8 + 8 * refSteps * maxLatency);
    refReady = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (halted);
    // Quiet window in which no bus cycle may start
    repeat (20) @(posedge clk);
    if (instrAddr != finalPc) begin
      valueErrors++;
      $display("FAILED at %0t: halt PC expected %h, got %h", $time, finalPc, instrAddr);
    end
    if (storeIdx != expAdr.size()) begin
      otherErrors++;
      $display("Store count wrong, saw %0d but expected %0d", storeIdx, expAdr.size());
    end
    finishRun();
  end

  // Watchdog
  initial begin
    wait (refReady);
    #(timeLimit);
    otherErrors++;
    $display("Timeout, core did not halt within %0t", timeLimit);
    finishRun();
  end

endmodule

// ==== filelist.f ====
logic/isaPkg.sv
logic/busPkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/branchUnit.sv
logic/dataBusMaster.sv
logic/cpuCore.sv
sim/wbMemModel.sv
sim/cpuTb.sv
